/* dg_pkg.sv */
package dg_pkg;

    // Graph stage command, a plain level shared by every unit and link
    typedef enum logic [2:0] {
        STAGE_IDLE                = 3'd0,
        STAGE_MEASUREMENT_LOADING = 3'd1,
        STAGE_GROW                = 3'd2,
        STAGE_MERGE               = 3'd3,
        STAGE_RESET_GRAPH         = 3'd4
    } stage_e;

    // Link slot of a processing unit
    typedef enum logic [2:0] {
        DIR_NORTH = 3'd0,  // Row i-1
        DIR_SOUTH = 3'd1,  // Row i+1
        DIR_WEST  = 3'd2,  // Column j-1
        DIR_EAST  = 3'd3,  // Column j+1
        DIR_DOWN  = 3'd4,  // Older round k-1
        DIR_UP    = 3'd5   // Newer round k+1
    } dir_e;

    localparam int NEIGHBOR_COUNT = 6;

    // Vertex address: {k, i, j} with each field clog2 of its grid width
    localparam int ADDRESS_WIDTH = 8;
    typedef logic [ADDRESS_WIDTH-1:0] address_t;

    localparam int WEIGHT_WIDTH = 4;
    typedef logic [WEIGHT_WIDTH-1:0] weight_t;

    // Unit to link, one per slot
    typedef struct packed {
        logic     grow;  // Defect bit of the unit
        address_t root;
    } pu_link_t;

    // Link back to unit, one per slot
    typedef struct packed {
        logic     fully_grown;
        address_t peer_root;  // Root of the unit across the link
    } link_pu_t;

endpackage

/* processing_unit.sv */
`timescale 1ns/1ps

module processing_unit #(
    parameter dg_pkg::address_t ADDRESS = '0
) (
    input  logic                                           clk,
    input  logic                                           rst_n_i,
    input  dg_pkg::stage_e                                 global_stage_i,

    input  logic                                           measurement_i,
    output logic                                           measurement_o,

    input  dg_pkg::link_pu_t [dg_pkg::NEIGHBOR_COUNT-1:0]  neighbor_i,
    output dg_pkg::pu_link_t [dg_pkg::NEIGHBOR_COUNT-1:0]  neighbor_o,

    output dg_pkg::address_t                               root_o,
    output logic                                           busy_o
);

    import dg_pkg::*;

    logic     measurement_q;  // Defect bit of this vertex for the current layer
    address_t root_q;
    address_t root_min;
    logic     busy_q;

    // Smallest root visible over the fully grown links
    always_comb begin
        root_min = root_q;
        for (int n = 0; n < NEIGHBOR_COUNT; n++) begin
            if (neighbor_i[n].fully_grown && (neighbor_i[n].peer_root < root_min)) begin
                root_min = neighbor_i[n].peer_root;
            end
        end
    end

    // Measurement shift register, one step per loading cycle
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            measurement_q <= 1'b0;
        end else begin
            case (global_stage_i)
                STAGE_MEASUREMENT_LOADING: measurement_q <= measurement_i;
                STAGE_RESET_GRAPH:         measurement_q <= 1'b0;
                default:                   measurement_q <= measurement_q;
            endcase
        end
    end

    // Root register and merge activity flag
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            root_q <= ADDRESS;
            busy_q <= 1'b0;
        end else begin
            case (global_stage_i)
                STAGE_MERGE: begin
                    root_q <= root_min;
                    busy_q <= (root_min != root_q);  // Still settling
                end
                STAGE_RESET_GRAPH: begin
                    root_q <= ADDRESS;
                    busy_q <= 1'b0;
                end
                STAGE_IDLE: begin
                    root_q <= root_q;
                    busy_q <= busy_q;
                end
                default: begin
                    // Loading and growing leave the roots alone
                    root_q <= root_q;
                    busy_q <= 1'b0;
                end
            endcase
        end
    end

    // Same request and root on every slot
    always_comb begin
        for (int n = 0; n < NEIGHBOR_COUNT; n++) begin
            neighbor_o[n].grow = measurement_q;
            neighbor_o[n].root = root_q;
        end
    end

    assign measurement_o = measurement_q;  // On to the same (i, j) one round older
    assign root_o        = root_q;
    assign busy_o        = busy_q;

endmodule

/* neighbor_link.sv */
`timescale 1ns/1ps

module neighbor_link #(
    parameter int MAX_WEIGHT = 2
) (
    input  logic             clk,
    input  logic             rst_n_i,
    input  dg_pkg::stage_e   global_stage_i,

    input  dg_pkg::pu_link_t a_i,
    input  dg_pkg::pu_link_t b_i,
    output dg_pkg::link_pu_t a_o,
    output dg_pkg::link_pu_t b_o
);

    import dg_pkg::*;

    localparam weight_t                 MAX_W   = weight_t'(MAX_WEIGHT);
    localparam logic [WEIGHT_WIDTH:0]   MAX_SUM = {1'b0, MAX_W};

    weight_t                 growth_q;
    logic [1:0]              grow_count;  // 0, 1 or 2 sides asking to grow
    logic [WEIGHT_WIDTH:0]   growth_sum;  // One spare bit for the carry
    logic                    fully_grown;

    assign grow_count = {1'b0, a_i.grow} + {1'b0, b_i.grow};
    assign growth_sum = {1'b0, growth_q} + {{(WEIGHT_WIDTH-1){1'b0}}, grow_count};

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            growth_q <= '0;
        end else begin
            case (global_stage_i)
                STAGE_GROW: begin
                    if (growth_sum >= MAX_SUM) begin
                        growth_q <= MAX_W;  // Saturate
                    end else begin
                        growth_q <= growth_sum[WEIGHT_WIDTH-1:0];
                    end
                end
                STAGE_RESET_GRAPH: growth_q <= '0;
                default:           growth_q <= growth_q;
            endcase
        end
    end

    assign fully_grown = (growth_q == MAX_W);

    // Roots cross over, each side sees the other one
    assign a_o.fully_grown = fully_grown;
    assign a_o.peer_root   = b_i.root;
    assign b_o.fully_grown = fully_grown;
    assign b_o.peer_root   = a_i.root;

endmodule

/* decoding_graph.sv */
`timescale 1ns/1ps

module decoding_graph #(
    parameter int GRID_WIDTH_X = 4,
    parameter int GRID_WIDTH_Z = 3,
    parameter int GRID_WIDTH_U = 3,
    parameter int MAX_WEIGHT   = 2
) (
    input  logic                                                     clk,
    input  logic                                                     rst_n_i,
    input  logic [GRID_WIDTH_X*GRID_WIDTH_Z-1:0]                     measurements_i,
    input  dg_pkg::stage_e                                           global_stage_i,
    output dg_pkg::address_t [GRID_WIDTH_X*GRID_WIDTH_Z*GRID_WIDTH_U-1:0] roots_o,
    output logic [GRID_WIDTH_X*GRID_WIDTH_Z*GRID_WIDTH_U-1:0]        busy_o
);

    import dg_pkg::*;

    localparam int X_BITS       = $clog2(GRID_WIDTH_X);
    localparam int Z_BITS       = $clog2(GRID_WIDTH_Z);
    localparam int PU_PER_ROUND = GRID_WIDTH_X * GRID_WIDTH_Z;
    localparam int PU_COUNT     = PU_PER_ROUND * GRID_WIDTH_U;

    // Per unit slot buses, indexed i*Z + j + k*X*Z
    pu_link_t [NEIGHBOR_COUNT-1:0] pu_out [PU_COUNT];
    wire link_pu_t [NEIGHBOR_COUNT-1:0] pu_in [PU_COUNT];

    logic [PU_COUNT-1:0] meas_in;
    logic [PU_COUNT-1:0] meas_out;

    for (genvar k = 0; k < GRID_WIDTH_U; k++) begin : g_k
        for (genvar i = 0; i < GRID_WIDTH_X; i++) begin : g_i
            for (genvar j = 0; j < GRID_WIDTH_Z; j++) begin : g_j
                localparam int       IDX  = i * GRID_WIDTH_Z + j + k * PU_PER_ROUND;
                localparam address_t ADDR =
                    address_t'((k << (X_BITS + Z_BITS)) + (i << Z_BITS) + j);

                processing_unit #(
                    .ADDRESS (ADDR)
                ) i_pu (
                    .clk            (clk),
                    .rst_n_i        (rst_n_i),
                    .global_stage_i (global_stage_i),
                    .measurement_i  (meas_in[IDX]),
                    .measurement_o  (meas_out[IDX]),
                    .neighbor_i     (pu_in[IDX]),
                    .neighbor_o     (pu_out[IDX]),
                    .root_o         (roots_o[IDX]),
                    .busy_o         (busy_o[IDX])
                );

                // Newest round enters at the top, older ones move down
                if (k == GRID_WIDTH_U - 1) begin : g_meas_top
                    assign meas_in[IDX] = measurements_i[i * GRID_WIDTH_Z + j];
                end else begin : g_meas_shift
                    assign meas_in[IDX] = meas_out[IDX + PU_PER_ROUND];
                end

                // NS link, (i-1, j, k) SOUTH to (i, j, k) NORTH
                if (i > 0) begin : g_ns
                    neighbor_link #(
                        .MAX_WEIGHT (MAX_WEIGHT)
                    ) i_link (
                        .clk            (clk),
                        .rst_n_i        (rst_n_i),
                        .global_stage_i (global_stage_i),
                        .a_i            (pu_out[IDX - GRID_WIDTH_Z][DIR_SOUTH]),
                        .b_i            (pu_out[IDX][DIR_NORTH]),
                        .a_o            (pu_in[IDX - GRID_WIDTH_Z][DIR_SOUTH]),
                        .b_o            (pu_in[IDX][DIR_NORTH])
                    );
                end else begin : g_ns_edge
                    assign pu_in[IDX][DIR_NORTH] = '0;
                end

                if (i == GRID_WIDTH_X - 1) begin : g_south_edge
                    assign pu_in[IDX][DIR_SOUTH] = '0;
                end

                // EW link, (i, j-1, k) EAST to (i, j, k) WEST
                if (j > 0) begin : g_ew
                    neighbor_link #(
                        .MAX_WEIGHT (MAX_WEIGHT)
                    ) i_link (
                        .clk            (clk),
                        .rst_n_i        (rst_n_i),
                        .global_stage_i (global_stage_i),
                        .a_i            (pu_out[IDX - 1][DIR_EAST]),
                        .b_i            (pu_out[IDX][DIR_WEST]),
                        .a_o            (pu_in[IDX - 1][DIR_EAST]),
                        .b_o            (pu_in[IDX][DIR_WEST])
                    );
                end else begin : g_ew_edge
                    assign pu_in[IDX][DIR_WEST] = '0;
                end

                if (j == GRID_WIDTH_Z - 1) begin : g_east_edge
                    assign pu_in[IDX][DIR_EAST] = '0;
                end

                // UD link, (i, j, k-1) UP to (i, j, k) DOWN
                if (k > 0) begin : g_ud
                    neighbor_link #(
                        .MAX_WEIGHT (MAX_WEIGHT)
                    ) i_link (
                        .clk            (clk),
                        .rst_n_i        (rst_n_i),
                        .global_stage_i (global_stage_i),
                        .a_i            (pu_out[IDX - PU_PER_ROUND][DIR_UP]),
                        .b_i            (pu_out[IDX][DIR_DOWN]),
                        .a_o            (pu_in[IDX - PU_PER_ROUND][DIR_UP]),
                        .b_o            (pu_in[IDX][DIR_DOWN])
                    );
                end else begin : g_ud_edge
                    assign pu_in[IDX][DIR_DOWN] = '0;  // Oldest round has nothing below
                end

                if (k == GRID_WIDTH_U - 1) begin : g_up_edge
                    assign pu_in[IDX][DIR_UP] = '0;
                end
            end
        end
    end

endmodule

/* tb_decoding_graph.sv */
`timescale 1ns/1ps

module tb_decoding_graph;

    import dg_pkg::*;

    localparam int GRID_WIDTH_X = 4;
    localparam int GRID_WIDTH_Z = 3;
    localparam int GRID_WIDTH_U = 3;
    localparam int MAX_WEIGHT   = 2;
    localparam int PU_PER_ROUND = GRID_WIDTH_X * GRID_WIDTH_Z;
    localparam int PU_COUNT     = PU_PER_ROUND * GRID_WIDTH_U;
    localparam int X_BITS       = $clog2(GRID_WIDTH_X);
    localparam int Z_BITS       = $clog2(GRID_WIDTH_Z);
    localparam int MAX_TESTS    = 32;
    localparam int MERGE_LIMIT  = PU_COUNT + 4;

    logic                    clk;
    logic                    rst_n_i;
    logic [PU_PER_ROUND-1:0] measurements;
    stage_e                  stage;
    address_t [PU_COUNT-1:0] roots;
    logic [PU_COUNT-1:0]     busy;

    // Test vectors, one entry per record of the data file
    string                   test_name  [MAX_TESTS];
    logic [PU_PER_ROUND-1:0] test_round [MAX_TESTS][GRID_WIDTH_U];
    int                      test_grow  [MAX_TESTS];
    address_t                test_root  [MAX_TESTS][PU_COUNT];
    int                      test_count;
    bit                      data_ready;
    int                      error_count;

    decoding_graph #(
        .GRID_WIDTH_X (GRID_WIDTH_X),
        .GRID_WIDTH_Z (GRID_WIDTH_Z),
        .GRID_WIDTH_U (GRID_WIDTH_U),
        .MAX_WEIGHT   (MAX_WEIGHT)
    ) i_dut (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .measurements_i (measurements),
        .global_stage_i (stage),
        .roots_o        (roots),
        .busy_o         (busy)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;

    // Address {k, i, j} of a vertex from its position in roots_o
    function automatic address_t own_address(input int idx);
        int k;
        int i;
        int j;
        k = idx / PU_PER_ROUND;
        i = (idx % PU_PER_ROUND) / GRID_WIDTH_Z;
        j = idx % GRID_WIDTH_Z;
        return address_t'((k << (X_BITS + Z_BITS)) | (i << Z_BITS) | j);
    endfunction

    task automatic read_testdata();
        int    fd;
        string line;
        string name;
        int    fields;
        int    layer;  // Next root line of the record, U means a header line
        int    m0;
        int    m1;
        int    m2;
        int    grow;
        int    v [PU_PER_ROUND];
        test_count = 0;
        layer      = GRID_WIDTH_U;
        fd = $fopen("decoding_graph_testdata.txt", "r");
        if (fd == 0) begin
            $display("Could not open decoding_graph_testdata.txt");
            error_count++;
            return;
        end
        while ($fgets(line, fd) != 0) begin
            if (line.len() == 0 || line.getc(0) == "#" || line.getc(0) == "\n") begin
                continue;
            end
            if (test_count >= MAX_TESTS) begin
                $display("Too many records in the test data file");
                error_count++;
                break;
            end
            if (layer == GRID_WIDTH_U) begin
                fields = $sscanf(line, "%s %h %h %h %d", name, m0, m1, m2, grow);
                if (fields != 5) begin
                    $display("Malformed record header in the test data file: %s", line);
                    error_count++;
                end
                test_name[test_count]     = name;
                test_round[test_count][0] = m0[PU_PER_ROUND-1:0];
                test_round[test_count][1] = m1[PU_PER_ROUND-1:0];
                test_round[test_count][2] = m2[PU_PER_ROUND-1:0];
                test_grow[test_count]     = grow;
                layer = 0;
            end else begin
                fields = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h",
                                 v[0], v[1], v[2], v[3], v[4], v[5],
                                 v[6], v[7], v[8], v[9], v[10], v[11]);
                if (fields != PU_PER_ROUND) begin
                    $display("Malformed root line in the test data file: %s", line);
                    error_count++;
                end
                for (int p = 0; p < PU_PER_ROUND; p++) begin
                    test_root[test_count][layer * PU_PER_ROUND + p] = address_t'(v[p]);
                end
                layer++;
                if (layer == GRID_WIDTH_U) begin
                    test_count++;
                end
            end
        end
        $fclose(fd);
        if (test_count == 0) begin
            $display("No complete test record found in the test data file");
            error_count++;
        end
    endtask

    // Drive on the falling edge, DUT samples at the rising edge in between
    task automatic apply_stage(input stage_e s, input logic [PU_PER_ROUND-1:0] m);
        stage        = s;
        measurements = m;
        @(negedge clk);
    endtask

    task automatic merge_until_settled(input string name, output logic first_busy);
        int cycles;
        bit settled;
        cycles     = 0;
        settled    = 1'b0;
        first_busy = 1'b0;
        while (!settled && cycles < MERGE_LIMIT) begin
            apply_stage(STAGE_MERGE, '0);
            if (cycles == 0) begin
                first_busy = |busy;
            end
            cycles++;
            if (busy == '0) begin
                settled = 1'b1;  // No root moved in the last cycle
            end
        end
        if (!settled) begin
            $display("%s: merge still busy after %0d cycles", name, MERGE_LIMIT);
            error_count++;
        end
        apply_stage(STAGE_IDLE, '0);
    endtask

    task automatic check_root(input string name, input int idx, input address_t expected);
        if (roots[idx] !== expected) begin
            $display("[ERROR] %s vertex %0d: expected root %h, actual root %h",
                     name, idx, expected, roots[idx]);
            error_count++;
        end
    endtask

    task automatic check_own_roots(input string name);
        for (int idx = 0; idx < PU_COUNT; idx++) begin
            check_root(name, idx, own_address(idx));
        end
        if (busy !== '0) begin
            $display("[ERROR] %s busy: expected %h, actual %h", name, {PU_COUNT{1'b0}}, busy);
            error_count++;
        end
    endtask

    task automatic run_test(input int t);
        logic first_busy;
        logic expect_change;
        expect_change = 1'b0;
        apply_stage(STAGE_RESET_GRAPH, '0);
        for (int r = 0; r < GRID_WIDTH_U; r++) begin
            apply_stage(STAGE_MEASUREMENT_LOADING, test_round[t][r]);  // First round ends in layer 0
        end
        for (int g = 0; g < test_grow[t]; g++) begin
            apply_stage(STAGE_GROW, '0);
        end
        merge_until_settled(test_name[t], first_busy);
        for (int idx = 0; idx < PU_COUNT; idx++) begin
            if (test_root[t][idx] != own_address(idx)) begin
                expect_change = 1'b1;
            end
        end
        // Any root that must move has to move in the first merge cycle
        if (first_busy !== expect_change) begin
            $display("[ERROR] %s busy after first merge cycle: expected %b, actual %b",
                     test_name[t], expect_change, first_busy);
            error_count++;
        end
        for (int idx = 0; idx < PU_COUNT; idx++) begin
            check_root(test_name[t], idx, test_root[t][idx]);
        end
    endtask

    initial begin
        logic first_busy;
        rst_n_i      = 1'b0;
        stage        = STAGE_IDLE;
        measurements = '0;
        error_count  = 0;
        data_ready   = 1'b0;
        read_testdata();
        data_ready = 1'b1;
        repeat (16) @(negedge clk);
        rst_n_i = 1'b1;
        @(negedge clk);
        check_own_roots("reset");
        for (int t = 0; t < test_count; t++) begin
            run_test(t);
        end
        // Clear the merged graph, then merge with nothing grown
        apply_stage(STAGE_RESET_GRAPH, '0);
        check_own_roots("graph_reset");
        merge_until_settled("graph_reset_merge", first_busy);
        check_own_roots("graph_reset_merge");
        $display("Tests run: %0d, errors: %0d", test_count, error_count);
        if (error_count == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

    // Watchdog sized from the number of records
    initial begin
        wait (data_ready);
        repeat (test_count * 64 + 100) @(posedge clk);
        $display("Timeout: simulation did not finish within %0d cycles",
                 test_count * 64 + 100);
        $display("Verification failed");
        $finish;
    end

endmodule

/* decoding_graph_testdata.txt */
# Header: name, measurement rounds 0..U-1 in hex (first applied first), grow cycles
# Then U lines of expected roots in hex, layer k = 0 first, vertex i*Z+j left to right

no_defects 000 000 000 2
00 01 02 04 05 06 08 09 0a 0c 0d 0e
10 11 12 14 15 16 18 19 1a 1c 1d 1e
20 21 22 24 25 26 28 29 2a 2c 2d 2e

single_grow2 000 010 000 2
00 01 02 04 05 06 08 09 0a 0c 0d 0e
10 05 12 05 05 05 18 05 1a 1c 1d 1e
20 21 22 24 05 26 28 29 2a 2c 2d 2e

single_grow1 000 010 000 1
00 01 02 04 05 06 08 09 0a 0c 0d 0e
10 11 12 14 15 16 18 19 1a 1c 1d 1e
20 21 22 24 25 26 28 29 2a 2c 2d 2e

pair_adjacent 000 0c0 000 1
00 01 02 04 05 06 08 09 0a 0c 0d 0e
10 11 12 14 15 16 18 18 1a 1c 1d 1e
20 21 22 24 25 26 28 29 2a 2c 2d 2e

pair_grow3 000 0c0 000 3
00 01 02 04 05 06 08 08 0a 0c 0d 0e
10 11 12 08 08 16 08 08 08 08 08 1e
20 21 22 24 25 26 08 08 2a 2c 2d 2e

line_hops 000 000 f24 1
00 01 02 04 05 06 08 09 0a 0c 0d 0e
10 11 12 14 15 16 18 19 1a 1c 1d 1e
20 21 22 24 25 22 28 29 22 22 22 22

first_round 800 000 000 2
00 01 02 04 05 06 08 09 0a 0c 0a 0a
10 11 12 14 15 16 18 19 1a 1c 1d 0a
20 21 22 24 25 26 28 29 2a 2c 2d 2e

last_round 000 000 001 2
00 01 02 04 05 06 08 09 0a 0c 0d 0e
10 11 12 14 15 16 18 19 1a 1c 1d 1e
10 10 22 10 25 26 28 29 2a 2c 2d 2e

two_rounds_joined 001 000 001 2
00 00 02 00 05 06 08 09 0a 0c 0d 0e
00 11 12 14 15 16 18 19 1a 1c 1d 1e
00 00 22 00 25 26 28 29 2a 2c 2d 2e

/* filelist.f */
dg_pkg.sv
processing_unit.sv
neighbor_link.sv
decoding_graph.sv
tb_decoding_graph.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the decoding graph testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary -Wno-fatal -f filelist.f --top-module tb_decoding_graph -o tb_decoding_graph

./obj_dir/tb_decoding_graph > sim.log 2>&1 || true
cat sim.log

if grep -q "Verification passed" sim.log; then
    echo "Simulation PASS"
    exit 0
else
    echo "Simulation FAIL"
    exit 1
fi
